/* flist.f */
design/pipe_pkg.sv
design/reg_file.sv
design/inflight_tracker.sv
design/hazard_unit.sv
design/operand_select.sv
design/issue_stage_top.sv
tests/tb_issue_stage.sv

/* Makefile */
# Verilator build and run of the issue-stage testbench.
# Any variable can be overridden, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_issue_stage
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM       ?= $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS SIM"

# the simulator exits non-zero on $$fatal, so make fails with it.
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* tests/tb_issue_stage.sv */
`timescale 1ns/1ps

module tb_issue_stage;

    localparam int cycle_limit = 2000;

    logic                      clk;
    logic                      reset;
    pipe_pkg::id_inst_t        id_inst;
    logic [pipe_pkg::xlen-1:0] ex_data;
    logic [pipe_pkg::xlen-1:0] mem_load_data;
    logic                      stall;
    pipe_pkg::issue_op_t       issue_op;

    // architectural registers, and the EX, MEM, WB stages youngest first.
    logic [pipe_pkg::xlen-1:0] model_regs [pipe_pkg::reg_count];
    pipe_pkg::slot_t           model_pipe [3];
    int                        cycles;

    issue_stage_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .id_inst       (id_inst),
        .ex_data       (ex_data),
        .mem_load_data (mem_load_data),
        .stall         (stall),
        .issue_op      (issue_op)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display(">>> FAIL");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", cycle_limit);
        end
    end

    task automatic check_issue(
        input string               name,
        input pipe_pkg::issue_op_t exp,
        input pipe_pkg::issue_op_t act
    );
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "issued operands differ from the expected values");
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
            $display(">>> FAIL");
            $fatal(1, "stall differs from the expected value");
        end
    endtask

    function automatic pipe_pkg::id_inst_t make_inst(
        input pipe_pkg::inst_kind_e                kind,
        input logic [pipe_pkg::reg_addr_width-1:0] rd,
        input logic [pipe_pkg::reg_addr_width-1:0] rs1,
        input logic [pipe_pkg::reg_addr_width-1:0] rs2
    );
        pipe_pkg::id_inst_t inst;
        inst.valid = 1'b1;
        inst.kind  = kind;
        inst.rd    = rd;
        inst.rs1   = rs1;
        inst.rs2   = rs2;
        return inst;
    endfunction

    function automatic pipe_pkg::issue_op_t expected_op(
        input pipe_pkg::id_inst_t        inst,
        input logic [pipe_pkg::xlen-1:0] v1,
        input logic [pipe_pkg::xlen-1:0] v2
    );
        pipe_pkg::issue_op_t op;
        op.valid   = inst.valid;
        op.kind    = inst.kind;
        op.rd      = inst.rd;
        op.rs1_val = v1;
        op.rs2_val = v2;
        return op;
    endfunction

    // youngest earlier writer of the register, else the architectural value.
    function automatic logic [pipe_pkg::xlen-1:0] operand_from_model(
        input logic [pipe_pkg::reg_addr_width-1:0] rs
    );
        if (rs == '0) begin
            return '0;
        end
        for (int i = 0; i < 3; i++) begin
            if (model_pipe[i].valid && (model_pipe[i].kind != pipe_pkg::kind_none)
                && (model_pipe[i].rd == rs)) begin
                return model_pipe[i].data;
            end
        end
        return model_regs[rs];
    endfunction

    function automatic logic load_use_expected(input pipe_pkg::id_inst_t inst);
        pipe_pkg::slot_t ex;
        ex = model_pipe[0];
        return inst.valid && ex.valid && (ex.kind == pipe_pkg::kind_load) && (ex.rd != '0)
            && ((ex.rd == inst.rs1) || (ex.rd == inst.rs2));
    endfunction

    task automatic model_advance(input pipe_pkg::issue_op_t op);
        pipe_pkg::slot_t wb;
        wb = model_pipe[2];
        if (wb.valid && (wb.kind != pipe_pkg::kind_none) && (wb.rd != '0)) begin
            model_regs[wb.rd] = wb.data;
        end
        model_pipe[2]       = model_pipe[1];
        model_pipe[1]       = model_pipe[0];
        model_pipe[0].valid = op.valid;
        model_pipe[0].kind  = op.kind;
        model_pipe[0].rd    = op.rd;
        model_pipe[0].data  = '0;
    endtask

    // one decode cycle. outputs stay stable until the next rising edge.
    task automatic issue_cycle(input pipe_pkg::id_inst_t inst, output logic stalled);
        pipe_pkg::issue_op_t exp_op;
        logic                exp_stall;
        @(negedge clk);
        id_inst       = inst;
        ex_data       = {$urandom, $urandom};
        mem_load_data = {$urandom, $urandom};
        model_pipe[0].data = ex_data;
        if (model_pipe[1].kind == pipe_pkg::kind_load) begin
            model_pipe[1].data = mem_load_data;
        end
        #1;
        exp_stall      = load_use_expected(inst);
        exp_op         = expected_op(inst, operand_from_model(inst.rs1),
                                     operand_from_model(inst.rs2));
        exp_op.valid   = inst.valid && !exp_stall;
        check_stall("stall", exp_stall, stall);
        check_issue("issue_op", exp_op, issue_op);
        stalled = exp_stall;
        model_advance(exp_op);
    endtask

    task automatic reset_reads();
        pipe_pkg::id_inst_t inst;
        logic               stalled;
        check_stall("stall", 1'b0, stall);
        for (int r = 0; r < pipe_pkg::reg_count; r += 2) begin
            inst = make_inst(pipe_pkg::kind_none, 5'd0, 5'(r), 5'(r + 1));
            issue_cycle(inst, stalled);
            check_issue("issue_op", expected_op(inst, '0, '0), issue_op);
        end
    endtask

    task automatic alu_forwarding();
        pipe_pkg::id_inst_t          inst;
        logic                        stalled;
        logic [pipe_pkg::xlen-1:0]   x5_val;
        logic [pipe_pkg::xlen-1:0]   x6_val;
        issue_cycle(make_inst(pipe_pkg::kind_alu, 5'd5, 5'd0, 5'd0), stalled);
        inst = make_inst(pipe_pkg::kind_alu, 5'd6, 5'd5, 5'd0);
        issue_cycle(inst, stalled);
        x5_val = ex_data;
        check_issue("issue_op", expected_op(inst, x5_val, '0), issue_op);
        inst = make_inst(pipe_pkg::kind_none, 5'd0, 5'd5, 5'd6);
        issue_cycle(inst, stalled);
        x6_val = ex_data;
        check_issue("issue_op", expected_op(inst, x5_val, x6_val), issue_op);
        // x5 walks WB then RF, x6 one stage behind.
        repeat (3) begin
            issue_cycle(inst, stalled);
            check_issue("issue_op", expected_op(inst, x5_val, x6_val), issue_op);
        end
    endtask

    task automatic load_use_stall();
        pipe_pkg::id_inst_t dep;
        logic               stalled;
        issue_cycle(make_inst(pipe_pkg::kind_load, 5'd7, 5'd0, 5'd0), stalled);
        dep = make_inst(pipe_pkg::kind_alu, 5'd8, 5'd7, 5'd0);
        issue_cycle(dep, stalled);
        check_stall("stall", 1'b1, stall);
        issue_cycle(dep, stalled);
        check_stall("stall", 1'b0, stall);
        check_issue("issue_op", expected_op(dep, mem_load_data, '0), issue_op);
        issue_cycle(make_inst(pipe_pkg::kind_load, 5'd9, 5'd0, 5'd0), stalled);
        dep = make_inst(pipe_pkg::kind_alu, 5'd10, 5'd3, 5'd4);
        issue_cycle(dep, stalled);
        check_stall("stall", 1'b0, stall);
        check_issue("issue_op", expected_op(dep, '0, '0), issue_op);
        issue_cycle(make_inst(pipe_pkg::kind_load, 5'd11, 5'd0, 5'd0), stalled);
        dep = make_inst(pipe_pkg::kind_none, 5'd0, 5'd0, 5'd11);
        issue_cycle(dep, stalled);
        check_stall("stall", 1'b1, stall);
        issue_cycle(dep, stalled);
        check_issue("issue_op", expected_op(dep, '0, mem_load_data), issue_op);
    endtask

    task automatic zero_and_none();
        pipe_pkg::id_inst_t inst;
        logic               stalled;
        issue_cycle(make_inst(pipe_pkg::kind_alu, 5'd0, 5'd0, 5'd0), stalled);
        issue_cycle(make_inst(pipe_pkg::kind_load, 5'd0, 5'd0, 5'd0), stalled);
        inst = make_inst(pipe_pkg::kind_alu, 5'd0, 5'd0, 5'd0);
        issue_cycle(inst, stalled);
        check_stall("stall", 1'b0, stall);
        check_issue("issue_op", expected_op(inst, '0, '0), issue_op);
        // a store-like op carries an rd field but never writes it.
        issue_cycle(make_inst(pipe_pkg::kind_none, 5'd12, 5'd0, 5'd0), stalled);
        inst = make_inst(pipe_pkg::kind_none, 5'd0, 5'd12, 5'd12);
        repeat (4) begin
            issue_cycle(inst, stalled);
            check_issue("issue_op", expected_op(inst, '0, '0), issue_op);
        end
    endtask

    task automatic forward_priority();
        pipe_pkg::id_inst_t        inst;
        logic                      stalled;
        logic [pipe_pkg::xlen-1:0] x14_val;
        logic [pipe_pkg::xlen-1:0] x15_val;
        repeat (3) begin
            issue_cycle(make_inst(pipe_pkg::kind_alu, 5'd13, 5'd0, 5'd0), stalled);
        end
        inst = make_inst(pipe_pkg::kind_none, 5'd0, 5'd13, 5'd13);
        issue_cycle(inst, stalled);
        check_issue("issue_op", expected_op(inst, ex_data, ex_data), issue_op);
        issue_cycle(make_inst(pipe_pkg::kind_alu, 5'd14, 5'd0, 5'd0), stalled);
        issue_cycle(make_inst(pipe_pkg::kind_alu, 5'd15, 5'd0, 5'd0), stalled);
        x14_val = ex_data;
        inst = make_inst(pipe_pkg::kind_none, 5'd0, 5'd14, 5'd15);
        issue_cycle(inst, stalled);
        x15_val = ex_data;
        check_issue("issue_op", expected_op(inst, x14_val, x15_val), issue_op);
        inst = make_inst(pipe_pkg::kind_none, 5'd0, 5'd15, 5'd14);
        issue_cycle(inst, stalled);
        check_issue("issue_op", expected_op(inst, x15_val, x14_val), issue_op);
    endtask

    task automatic random_stream(input int count);
        pipe_pkg::id_inst_t inst;
        logic               stalled;
        int                 issued;
        issued = 0;
        while (issued < count) begin
            if ($urandom % 8 == 0) begin
                issue_cycle('0, stalled);
            end else begin
                inst = make_inst(pipe_pkg::inst_kind_e'(2'($urandom % 3)), 5'($urandom % 6),
                                 5'($urandom % 6), 5'($urandom % 6));
                stalled = 1'b1;
                // held steady in decode until it issues.
                while (stalled) begin
                    issue_cycle(inst, stalled);
                end
                issued++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h8c04));
        clk           = 1'b0;
        reset         = 1'b1;
        id_inst       = '0;
        ex_data       = '0;
        mem_load_data = '0;
        cycles        = 0;
        for (int i = 0; i < pipe_pkg::reg_count; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 3; i++) begin
            model_pipe[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_reads();
        alu_forwarding();
        load_use_stall();
        zero_and_none();
        forward_priority();
        random_stream(200);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* design/issue_stage_top.sv */
`timescale 1ns/1ps

module issue_stage_top (
    input  logic                      clk,
    input  logic                      reset,
    input  pipe_pkg::id_inst_t        id_inst,
    input  logic [pipe_pkg::xlen-1:0] ex_data,
    input  logic [pipe_pkg::xlen-1:0] mem_load_data,
    output logic                      stall,
    output pipe_pkg::issue_op_t       issue_op
);

    pipe_pkg::slot_t           ex_slot;
    pipe_pkg::slot_t           mem_slot;
    pipe_pkg::slot_t           wb_slot;
    pipe_pkg::wb_port_t        wb_port;
    pipe_pkg::fwd_sel_e        rs1_sel;
    pipe_pkg::fwd_sel_e        rs2_sel;
    logic [pipe_pkg::xlen-1:0] rs1_data;
    logic [pipe_pkg::xlen-1:0] rs2_data;

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (id_inst.rs1),
        .rs2      (id_inst.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb_port)
    );

    // EX/MEM/WB destinations, plus the register file write.
    inflight_tracker u_tracker (
        .clk           (clk),
        .reset         (reset),
        .issue         (issue_op),
        .ex_data       (ex_data),
        .mem_load_data (mem_load_data),
        .ex_slot       (ex_slot),
        .mem_slot      (mem_slot),
        .wb_slot       (wb_slot),
        .wb            (wb_port)
    );

    hazard_unit u_hazard (
        .id       (id_inst),
        .ex_slot  (ex_slot),
        .mem_slot (mem_slot),
        .wb_slot  (wb_slot),
        .stall    (stall),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel)
    );

    operand_select u_operand_select (
        .id       (id_inst),
        .stall    (stall),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .ex_slot  (ex_slot),
        .mem_slot (mem_slot),
        .wb_slot  (wb_slot),
        .issue    (issue_op)
    );

endmodule

/* design/operand_select.sv */
`timescale 1ns/1ps

module operand_select (
    input  pipe_pkg::id_inst_t        id,
    input  logic                      stall,
    input  pipe_pkg::fwd_sel_e        rs1_sel,
    input  pipe_pkg::fwd_sel_e        rs2_sel,
    input  logic [pipe_pkg::xlen-1:0] rs1_data,
    input  logic [pipe_pkg::xlen-1:0] rs2_data,
    input  pipe_pkg::slot_t           ex_slot,
    input  pipe_pkg::slot_t           mem_slot,
    input  pipe_pkg::slot_t           wb_slot,
    output pipe_pkg::issue_op_t       issue
);

    function automatic logic [pipe_pkg::xlen-1:0] pick(
        input pipe_pkg::fwd_sel_e        sel,
        input logic [pipe_pkg::xlen-1:0] rf_val,
        input logic [pipe_pkg::xlen-1:0] ex_val,
        input logic [pipe_pkg::xlen-1:0] mem_val,
        input logic [pipe_pkg::xlen-1:0] wb_val
    );
        case (sel)
            pipe_pkg::fwd_ex:  return ex_val;
            pipe_pkg::fwd_mem: return mem_val;
            pipe_pkg::fwd_wb:  return wb_val;
            default:           return rf_val;
        endcase
    endfunction

    // held in decode while stalled.
    assign issue.valid = id.valid && !stall;
    assign issue.kind  = id.kind;
    assign issue.rd    = id.rd;

    assign issue.rs1_val = pick(rs1_sel, rs1_data, ex_slot.data, mem_slot.data,
                                wb_slot.data);
    assign issue.rs2_val = pick(rs2_sel, rs2_data, ex_slot.data, mem_slot.data,
                                wb_slot.data);

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  pipe_pkg::id_inst_t id,
    input  pipe_pkg::slot_t    ex_slot,
    input  pipe_pkg::slot_t    mem_slot,
    input  pipe_pkg::slot_t    wb_slot,
    output logic               stall,
    output pipe_pkg::fwd_sel_e rs1_sel,
    output pipe_pkg::fwd_sel_e rs2_sel
);

    logic rs1_ex_hit;
    logic rs1_mem_hit;
    logic rs1_wb_hit;
    logic rs2_ex_hit;
    logic rs2_mem_hit;
    logic rs2_wb_hit;
    logic load_use;

    // a slot only counts if it will really write this register.
    function automatic logic slot_hit(
        input logic [pipe_pkg::reg_addr_width-1:0] rs,
        input pipe_pkg::slot_t                     slot
    );
        return (rs != '0) && slot.valid && (slot.kind != pipe_pkg::kind_none)
            && (slot.rd == rs);
    endfunction

    // youngest producer wins.
    function automatic pipe_pkg::fwd_sel_e rank(
        input logic ex_hit,
        input logic mem_hit,
        input logic wb_hit
    );
        if (ex_hit) begin
            return pipe_pkg::fwd_ex;
        end else if (mem_hit) begin
            return pipe_pkg::fwd_mem;
        end else if (wb_hit) begin
            return pipe_pkg::fwd_wb;
        end
        return pipe_pkg::fwd_rf;
    endfunction

    assign rs1_ex_hit  = slot_hit(id.rs1, ex_slot);
    assign rs1_mem_hit = slot_hit(id.rs1, mem_slot);
    assign rs1_wb_hit  = slot_hit(id.rs1, wb_slot);
    assign rs2_ex_hit  = slot_hit(id.rs2, ex_slot);
    assign rs2_mem_hit = slot_hit(id.rs2, mem_slot);
    assign rs2_wb_hit  = slot_hit(id.rs2, wb_slot);

    // load data is not there until MEM, so a dependent op waits one cycle.
    assign load_use = (ex_slot.kind == pipe_pkg::kind_load) && (rs1_ex_hit || rs2_ex_hit);
    assign stall    = id.valid && load_use;

    assign rs1_sel = rank(rs1_ex_hit, rs1_mem_hit, rs1_wb_hit);
    assign rs2_sel = rank(rs2_ex_hit, rs2_mem_hit, rs2_wb_hit);

endmodule

/* design/inflight_tracker.sv */
`timescale 1ns/1ps

module inflight_tracker (
    input  logic                      clk,
    input  logic                      reset,
    input  pipe_pkg::issue_op_t       issue,
    input  logic [pipe_pkg::xlen-1:0] ex_data,
    input  logic [pipe_pkg::xlen-1:0] mem_load_data,
    output pipe_pkg::slot_t           ex_slot,
    output pipe_pkg::slot_t           mem_slot,
    output pipe_pkg::slot_t           wb_slot,
    output pipe_pkg::wb_port_t        wb
);

    logic                                ex_valid;
    pipe_pkg::inst_kind_e                ex_kind;
    logic [pipe_pkg::reg_addr_width-1:0] ex_rd;

    logic                                mem_valid;
    pipe_pkg::inst_kind_e                mem_kind;
    logic [pipe_pkg::reg_addr_width-1:0] mem_rd;
    logic [pipe_pkg::xlen-1:0]           mem_alu_data;

    pipe_pkg::slot_t                     wb_q;

    // valid bits shift every cycle, a stall enters EX as a bubble.
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid    <= 1'b0;
            mem_valid   <= 1'b0;
            wb_q.valid  <= 1'b0;
        end else begin
            ex_valid    <= issue.valid;
            mem_valid   <= ex_valid;
            wb_q.valid  <= mem_slot.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_kind      <= issue.kind;
        ex_rd        <= issue.rd;
        mem_kind     <= ex_kind;
        mem_rd       <= ex_rd;
        mem_alu_data <= ex_data;
        wb_q.kind    <= mem_slot.kind;
        wb_q.rd      <= mem_slot.rd;
        wb_q.data    <= mem_slot.data;
    end

    // alu result is live in EX.
    assign ex_slot = '{valid: ex_valid, kind: ex_kind, rd: ex_rd, data: ex_data};

    // a load's data arrives from memory during MEM.
    always_comb begin
        mem_slot.valid = mem_valid;
        mem_slot.kind  = mem_kind;
        mem_slot.rd    = mem_rd;
        if (mem_kind == pipe_pkg::kind_load) begin
            mem_slot.data = mem_load_data;
        end else begin
            mem_slot.data = mem_alu_data;
        end
    end

    assign wb_slot = wb_q;

    assign wb.en   = wb_q.valid && (wb_q.kind != pipe_pkg::kind_none) && (wb_q.rd != '0);
    assign wb.addr = wb_q.rd;
    assign wb.data = wb_q.data;

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [pipe_pkg::reg_addr_width-1:0] rs1,
    input  logic [pipe_pkg::reg_addr_width-1:0] rs2,
    output logic [pipe_pkg::xlen-1:0]           rs1_data,
    output logic [pipe_pkg::xlen-1:0]           rs2_data,
    input  pipe_pkg::wb_port_t                  wb
);

    logic [pipe_pkg::xlen-1:0] regs [pipe_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < pipe_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // x0 is hardwired, whatever the array holds.
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

/* design/pipe_pkg.sv */
package pipe_pkg;

    localparam int xlen = 64;
    localparam int reg_addr_width = 5;
    localparam int reg_count = 32;

    // what the instruction in decode will write back.
    typedef enum logic [1:0] {
        kind_none = 2'd0,
        kind_alu  = 2'd1,
        kind_load = 2'd2
    } inst_kind_e;

    // source of an issued operand.
    typedef enum logic [1:0] {
        fwd_rf  = 2'd0,
        fwd_ex  = 2'd1,
        fwd_mem = 2'd2,
        fwd_wb  = 2'd3
    } fwd_sel_e;

    typedef struct packed {
        logic                      valid;
        inst_kind_e                kind;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rd;
    } id_inst_t;

    typedef struct packed {
        logic                      valid;
        inst_kind_e                kind;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           data;
    } slot_t;

    typedef struct packed {
        logic                      valid;
        inst_kind_e                kind;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           rs1_val;
        logic [xlen-1:0]           rs2_val;
    } issue_op_t;

    typedef struct packed {
        logic                      en;
        logic [reg_addr_width-1:0] addr;
        logic [xlen-1:0]           data;
    } wb_port_t;

endpackage
